// File: clint_timer.sv
/*
 * CLINT timer
 * mtime with a clock prescaler, mtimecmp, and the machine timer interrupt
 */
`timescale 1ns/1ps
`default_nettype none

module clint_timer
    import soc_bus_pkg::*, soc_map_pkg::*;
#(
    parameter int TICK_DIV = 4
) (
    input  wire   clk,
    input  wire   i_rst_n,
    input  wire   i_req,
    input  addr_t i_addr,
    input  wire   i_we,
    input  word_t i_wdata,
    input  mask_t i_wmask,
    output logic  o_done,
    output word_t o_rdata,
    output logic  o_err,
    output logic  o_timer_irq
);

    localparam int PRESC_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PRESC_W-1:0] presc_q;
    logic               tick;
    word_t              mtime_q;
    word_t              mtimecmp_q;
    logic               hit_mtime;
    logic               hit_cmp;
    logic               mtime_wr;
    logic               cmp_wr;

    assign tick      = (presc_q == PRESC_W'(TICK_DIV - 1));
    assign hit_mtime = (i_addr == MTIME_ADDR);
    assign hit_cmp   = (i_addr == MTIMECMP_ADDR);
    assign mtime_wr  = i_req && i_we && hit_mtime;
    assign cmp_wr    = i_req && i_we && hit_cmp;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            presc_q     <= '0;
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            o_done      <= 1'b0;
            o_err       <= 1'b0;
            o_timer_irq <= 1'b0;
        end else begin
            presc_q <= tick ? '0 : presc_q + 1'b1;
            // a software write wins over the tick
            if (mtime_wr) begin
                mtime_q <= merge_bytes(mtime_q, i_wdata, i_wmask);
            end else if (tick) begin
                mtime_q <= mtime_q + 1'b1;
            end
            if (cmp_wr) begin
                mtimecmp_q <= merge_bytes(mtimecmp_q, i_wdata, i_wmask);
            end
            o_done      <= i_req;
            o_err       <= i_req && !(hit_mtime || hit_cmp);
            o_timer_irq <= (mtime_q >= mtimecmp_q);
        end
    end

    always_ff @(posedge clk) begin
        if (i_req) begin
            if (hit_mtime) begin
                o_rdata <= mtime_q;
            end else if (hit_cmp) begin
                o_rdata <= mtimecmp_q;
            end else begin
                o_rdata <= '0;
            end
        end
    end

    a_mtime_monotonic: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !$past(mtime_wr) |-> (mtime_q >= $past(mtime_q))
    ) else $error("mtime went backwards without a write");

endmodule

`default_nettype wire

// File: mmio_decode.sv
/*
 * MMIO address decoder
 * latches one request, routes it to RAM or CLINT by address,
 * answers unmapped or misaligned accesses with an error
 */
`timescale 1ns/1ps
`default_nettype none

module mmio_decode
    import soc_bus_pkg::*, soc_map_pkg::*;
(
    input  wire   clk,
    input  wire   i_rst_n,
    // requester side
    input  wire   i_req_valid,
    input  wire   i_req_we,
    input  addr_t i_req_addr,
    input  word_t i_req_wdata,
    input  mask_t i_req_wmask,
    // target strobes and shared access fields
    output logic  o_ram_req,
    output logic  o_clint_req,
    output addr_t o_acc_addr,
    output logic  o_acc_we,
    output word_t o_acc_wdata,
    output mask_t o_acc_wmask,
    // target answers
    input  wire   i_ram_done,
    input  word_t i_ram_rdata,
    input  wire   i_clint_done,
    input  word_t i_clint_rdata,
    input  wire   i_clint_err,
    // response to requester
    output logic  o_resp_valid,
    output word_t o_resp_rdata,
    output logic  o_resp_err
);

    target_e req_tgt;
    target_e tgt_q;
    logic    pend_q;
    logic    busy_q;
    addr_t   addr_q;
    logic    we_q;
    word_t   wdata_q;
    mask_t   wmask_q;

    // alignment first, then the two windows
    always_comb begin
        if (i_req_addr[ALIGN_BITS-1:0] != '0) begin
            req_tgt = tgt_none;
        end else if (i_req_addr[63:RAM_SIZE_LOG2] == RAM_BASE[63:RAM_SIZE_LOG2]) begin
            req_tgt = tgt_ram;
        end else if (i_req_addr[63:CLINT_SIZE_LOG2] == CLINT_BASE[63:CLINT_SIZE_LOG2]) begin
            req_tgt = tgt_clint;
        end else begin
            req_tgt = tgt_none;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            tgt_q  <= tgt_none;
            pend_q <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            pend_q <= i_req_valid;
            if (i_req_valid) begin
                tgt_q  <= req_tgt;
                busy_q <= 1'b1;
            end else if (o_resp_valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_req_valid) begin
            addr_q  <= i_req_addr;
            we_q    <= i_req_we;
            wdata_q <= i_req_wdata;
            wmask_q <= i_req_wmask;
        end
    end

    assign o_ram_req   = pend_q && (tgt_q == tgt_ram);
    assign o_clint_req = pend_q && (tgt_q == tgt_clint);
    assign o_acc_addr  = addr_q;
    assign o_acc_we    = we_q;
    assign o_acc_wdata = wdata_q;
    assign o_acc_wmask = wmask_q;

    // only the outstanding target may answer
    always_comb begin
        case (tgt_q)
            tgt_ram: begin
                o_resp_valid = i_ram_done;
                o_resp_rdata = i_ram_rdata;
                o_resp_err   = 1'b0;
            end
            tgt_clint: begin
                o_resp_valid = i_clint_done;
                o_resp_rdata = i_clint_rdata;
                o_resp_err   = i_clint_err;
            end
            default: begin
                o_resp_valid = pend_q;
                o_resp_rdata = '0;
                o_resp_err   = 1'b1;
            end
        endcase
    end

    // one request in flight, a new one may come with the response
    a_single_outstanding: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        (busy_q && !o_resp_valid) |-> !i_req_valid
    ) else $error("request issued while another is outstanding");

endmodule

`default_nettype wire

// File: ram_bridge.sv
/*
 * RAM bridge
 * turns masked 64-bit accesses into whole-word RAM reads and writes,
 * partial writes go through read-modify-write
 */
`timescale 1ns/1ps
`default_nettype none

module ram_bridge
    import soc_bus_pkg::*;
(
    input  wire   clk,
    input  wire   i_rst_n,
    // access from the decoder
    input  wire   i_req,
    input  addr_t i_addr,
    input  wire   i_we,
    input  word_t i_wdata,
    input  mask_t i_wmask,
    output logic  o_done,
    output word_t o_rdata,
    // external RAM port
    output logic  o_ram_rd_en,
    output addr_t o_ram_addr,
    input  word_t i_ram_rdata,
    output logic  o_ram_wr_en,
    output addr_t o_ram_wr_addr,
    output word_t o_ram_wr_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_merge,
        st_write
    } state_e;

    state_e state_q;
    state_e state_d;
    addr_t  addr_q;
    logic   we_q;
    word_t  wdata_q;
    mask_t  mask_q;
    word_t  merged;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (i_req) begin
                    // full-mask writes skip the read
                    if (i_we && (&i_wmask)) begin
                        state_d = st_write;
                    end else begin
                        state_d = st_read;
                    end
                end
            end
            st_read: begin
                state_d = st_merge;
            end
            st_merge: begin
                state_d = st_idle;
            end
            st_write: begin
                state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= st_idle;
            we_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (i_req && (state_q == st_idle)) begin
                we_q <= i_we;
            end
        end
    end

    // a read is kept as a merge with an empty mask
    always_ff @(posedge clk) begin
        if (i_req && (state_q == st_idle)) begin
            addr_q  <= i_addr;
            wdata_q <= i_wdata;
            mask_q  <= i_we ? i_wmask : '0;
        end
    end

    // old word arrives in the merge state
    assign merged = merge_bytes(i_ram_rdata, wdata_q, mask_q);

    assign o_ram_rd_en   = (state_q == st_read);
    assign o_ram_addr    = addr_q;
    assign o_ram_wr_en   = (state_q == st_write) || ((state_q == st_merge) && we_q);
    assign o_ram_wr_addr = addr_q;
    assign o_ram_wr_data = (state_q == st_write) ? wdata_q : merged;

    assign o_done  = (state_q == st_write) || (state_q == st_merge);
    assign o_rdata = merged;

    a_rd_wr_exclusive: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !(o_ram_rd_en && o_ram_wr_en)
    ) else $error("RAM read and write enabled together");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_soc_top -o Vtb_soc_top

status=0
./obj_dir/Vtb_soc_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "test passed" sim.log; then
    exit 1
fi
exit 0

// File: soc_bus_pkg.sv
/*
 * memory bus types
 * address, data and byte-enable types shared by the decoder and its targets,
 * plus the byte merge used for masked writes
 */
`default_nettype none

package soc_bus_pkg;

    typedef logic [63:0] addr_t;
    typedef logic [63:0] word_t;
    typedef logic [7:0]  mask_t;

    localparam int BYTES_PER_WORD = 8;
    // low address bits that must be zero for an aligned access
    localparam int ALIGN_BITS = $clog2(BYTES_PER_WORD);

    // take masked bytes from new_w, the rest from old_w
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input mask_t mask);
        word_t res;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            res[8*b +: 8] = mask[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// File: soc_map_pkg.sv
/*
 * SoC address map
 * RAM window, CLINT window and register addresses, and the decoder target
 */
`default_nettype none

package soc_map_pkg;

    // RAM window, 256 MiB
    localparam logic [63:0] RAM_BASE      = 64'h0000_0000_8000_0000;
    localparam int          RAM_SIZE_LOG2 = 28;

    // CLINT window, 64 KiB
    localparam logic [63:0] CLINT_BASE      = 64'h0000_0000_0200_0000;
    localparam int          CLINT_SIZE_LOG2 = 16;

    localparam logic [63:0] MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
    localparam logic [63:0] MTIME_ADDR    = 64'h0000_0000_0200_BFF8;

    // where a request goes
    typedef enum logic [1:0] {
        tgt_ram,
        tgt_clint,
        tgt_none
    } target_e;

endpackage

`default_nettype wire

// File: soc_top.sv
/*
 * SoC memory back end
 * single requester port decoded to the RAM bridge and the CLINT timer
 */
`timescale 1ns/1ps
`default_nettype none

module soc_top
    import soc_bus_pkg::*;
#(
    parameter int TICK_DIV = 4
) (
    input  wire   clk,
    input  wire   i_rst_n,
    // requester port
    input  wire   i_req_valid,
    input  wire   i_req_we,
    input  addr_t i_req_addr,
    input  word_t i_req_wdata,
    input  mask_t i_req_wmask,
    output logic  o_resp_valid,
    output word_t o_resp_rdata,
    output logic  o_resp_err,
    output logic  o_timer_irq,
    // external RAM port
    output logic  o_ram_rd_en,
    output addr_t o_ram_addr,
    input  word_t i_ram_rdata,
    output logic  o_ram_wr_en,
    output addr_t o_ram_wr_addr,
    output word_t o_ram_wr_data
);

    logic  ram_req;
    logic  clint_req;
    addr_t acc_addr;
    logic  acc_we;
    word_t acc_wdata;
    mask_t acc_wmask;
    logic  ram_done;
    word_t ram_rdata;
    logic  clint_done;
    word_t clint_rdata;
    logic  clint_err;

    mmio_decode u_mmio_decode (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_req_valid   (i_req_valid),
        .i_req_we      (i_req_we),
        .i_req_addr    (i_req_addr),
        .i_req_wdata   (i_req_wdata),
        .i_req_wmask   (i_req_wmask),
        .o_ram_req     (ram_req),
        .o_clint_req   (clint_req),
        .o_acc_addr    (acc_addr),
        .o_acc_we      (acc_we),
        .o_acc_wdata   (acc_wdata),
        .o_acc_wmask   (acc_wmask),
        .i_ram_done    (ram_done),
        .i_ram_rdata   (ram_rdata),
        .i_clint_done  (clint_done),
        .i_clint_rdata (clint_rdata),
        .i_clint_err   (clint_err),
        .o_resp_valid  (o_resp_valid),
        .o_resp_rdata  (o_resp_rdata),
        .o_resp_err    (o_resp_err)
    );

    ram_bridge u_ram_bridge (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_req         (ram_req),
        .i_addr        (acc_addr),
        .i_we          (acc_we),
        .i_wdata       (acc_wdata),
        .i_wmask       (acc_wmask),
        .o_done        (ram_done),
        .o_rdata       (ram_rdata),
        .o_ram_rd_en   (o_ram_rd_en),
        .o_ram_addr    (o_ram_addr),
        .i_ram_rdata   (i_ram_rdata),
        .o_ram_wr_en   (o_ram_wr_en),
        .o_ram_wr_addr (o_ram_wr_addr),
        .o_ram_wr_data (o_ram_wr_data)
    );

    clint_timer #(
        .TICK_DIV (TICK_DIV)
    ) u_clint_timer (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req       (clint_req),
        .i_addr      (acc_addr),
        .i_we        (acc_we),
        .i_wdata     (acc_wdata),
        .i_wmask     (acc_wmask),
        .o_done      (clint_done),
        .o_rdata     (clint_rdata),
        .o_err       (clint_err),
        .o_timer_irq (o_timer_irq)
    );

endmodule

`default_nettype wire

// File: src.f
soc_bus_pkg.sv
soc_map_pkg.sv
mmio_decode.sv
ram_bridge.sv
clint_timer.sv
soc_top.sv
tb_soc_top.sv

// File: tb_soc_top.sv
/*
 * testbench for the SoC memory back end
 * table of RAM and error accesses against a RAM model,
 * then mtime, mtimecmp and timer interrupt sequences
 */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;

    import soc_bus_pkg::*;
    import soc_map_pkg::*;

    localparam int TICK_DIV     = 4;
    localparam int RESP_TIMEOUT = 20;
    localparam int NUM_PRELOAD  = 16;

    typedef struct packed {
        logic  we;
        addr_t addr;
        word_t wdata;
        mask_t mask;
        word_t exp_word;
        logic  chk_rdata;
        logic  exp_err;
        logic  exp_wr;
    } entry_t;

    logic  clk = 1'b0;
    logic  i_rst_n;
    logic  i_req_valid;
    logic  i_req_we;
    addr_t i_req_addr;
    word_t i_req_wdata;
    mask_t i_req_wmask;
    logic  o_resp_valid;
    word_t o_resp_rdata;
    logic  o_resp_err;
    logic  o_timer_irq;
    logic  o_ram_rd_en;
    addr_t o_ram_addr;
    logic  o_ram_wr_en;
    addr_t o_ram_wr_addr;
    word_t o_ram_wr_data;
    word_t ram_rdata = '0;

    // RAM model state
    word_t  ram_mem [addr_t];
    word_t  shadow [addr_t];
    addr_t  last_wr_addr = '0;
    word_t  last_wr_data = '0;
    int     ram_wr_count = 0;
    integer seed = 32'hf7b;
    entry_t tbl [$];

    always #4 clk = ~clk;

    soc_top #(
        .TICK_DIV (TICK_DIV)
    ) i_soc_top (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_req_valid   (i_req_valid),
        .i_req_we      (i_req_we),
        .i_req_addr    (i_req_addr),
        .i_req_wdata   (i_req_wdata),
        .i_req_wmask   (i_req_wmask),
        .o_resp_valid  (o_resp_valid),
        .o_resp_rdata  (o_resp_rdata),
        .o_resp_err    (o_resp_err),
        .o_timer_irq   (o_timer_irq),
        .o_ram_rd_en   (o_ram_rd_en),
        .o_ram_addr    (o_ram_addr),
        .i_ram_rdata   (ram_rdata),
        .o_ram_wr_en   (o_ram_wr_en),
        .o_ram_wr_addr (o_ram_wr_addr),
        .o_ram_wr_data (o_ram_wr_data)
    );

    // words never written read back as a pattern of the whole address
    function automatic word_t fill_word(input addr_t a);
        return {a[31:0], a[63:32]} ^ 64'hC3C3_5A5A_0F0F_9669;
    endfunction

    function automatic word_t model_read(input addr_t a);
        return ram_mem.exists(a) ? ram_mem[a] : fill_word(a);
    endfunction

    function automatic word_t shadow_read(input addr_t a);
        return shadow.exists(a) ? shadow[a] : fill_word(a);
    endfunction

    // byte lanes selected by the mask come from the new word
    function automatic word_t expect_merge(input word_t old_w, input word_t new_w,
                                           input mask_t m);
        word_t lanes;
        lanes = '0;
        for (int i = 0; i < 8; i++) begin
            if (m[i]) begin
                lanes = lanes | (64'hFF << (8 * i));
            end
        end
        return (old_w & ~lanes) | (new_w & lanes);
    endfunction

    // read data one cycle after the read strobe
    always @(posedge clk) begin
        if (o_ram_rd_en) begin
            ram_rdata <= model_read(o_ram_addr);
        end
        if (o_ram_wr_en) begin
            ram_mem[o_ram_wr_addr] = o_ram_wr_data;
            last_wr_addr <= o_ram_wr_addr;
            last_wr_data <= o_ram_wr_data;
            ram_wr_count <= ram_wr_count + 1;
        end
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_irq(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic preload_ram();
        logic [31:0] hi;
        logic [31:0] lo;
        addr_t       a;
        for (int i = 0; i < NUM_PRELOAD; i++) begin
            hi = $random(seed);
            lo = $random(seed);
            a = RAM_BASE + 64'(8 * i);
            ram_mem[a] = {hi, lo};
            shadow[a] = {hi, lo};
        end
    endtask

    task automatic add_read(input addr_t a);
        tbl.push_back('{1'b0, a, '0, '0, shadow_read(a), 1'b1, 1'b0, 1'b0});
    endtask

    task automatic add_write(input addr_t a, input word_t d, input mask_t m);
        word_t merged;
        merged = expect_merge(shadow_read(a), d, m);
        shadow[a] = merged;
        tbl.push_back('{1'b1, a, d, m, merged, 1'b0, 1'b0, 1'b1});
    endtask

    task automatic add_error(input logic we, input addr_t a);
        tbl.push_back('{we, a, 64'h5555_AAAA_5555_AAAA, 8'hFF, '0, 1'b0, 1'b1, 1'b0});
    endtask

    task automatic build_table();
        add_read(RAM_BASE);
        add_read(RAM_BASE + 64'h38);
        // top word of the RAM window, never preloaded
        add_read(RAM_BASE + 64'h0FFF_FFF8);
        add_write(RAM_BASE + 64'h08, 64'h0123_4567_89AB_CDEF, 8'hFF);
        add_read(RAM_BASE + 64'h08);
        add_write(RAM_BASE + 64'h10, 64'hDEAD_BEEF_CAFE_F00D, 8'h0F);
        add_read(RAM_BASE + 64'h10);
        add_write(RAM_BASE + 64'h18, 64'h1122_3344_5566_7788, 8'hA5);
        add_read(RAM_BASE + 64'h18);
        // empty mask still rewrites the old word
        add_write(RAM_BASE + 64'h20, 64'hFFFF_0000_FFFF_0000, 8'h00);
        add_read(RAM_BASE + 64'h20);
        add_error(1'b0, 64'h0000_0000_1000_0000);
        add_error(1'b0, 64'h0000_0001_8000_0000);
        add_error(1'b0, RAM_BASE + 64'h4);
        add_error(1'b1, RAM_BASE + 64'hC);
        add_error(1'b0, CLINT_BASE);
        add_error(1'b1, CLINT_BASE + 64'h8);
        add_error(1'b0, MTIME_ADDR + 64'h1);
    endtask

    // one request strobe, then wait for the response
    task automatic do_access(input logic we, input addr_t a, input word_t d, input mask_t m,
                             output word_t rdata, output logic err);
        int cycles;
        @(posedge clk);
        i_req_valid <= 1'b1;
        i_req_we    <= we;
        i_req_addr  <= a;
        i_req_wdata <= d;
        i_req_wmask <= m;
        @(posedge clk);
        i_req_valid <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!o_resp_valid && cycles < RESP_TIMEOUT);
        if (!o_resp_valid) begin
            $display("timeout: no response to the access at address %h", a);
            abort_run();
        end
        rdata = o_resp_rdata;
        err   = o_resp_err;
    endtask

    task automatic wait_irq(input logic level, input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (o_timer_irq !== level && cycles < limit);
        if (o_timer_irq !== level) begin
            $display("timeout: timer interrupt did not go %0s within %0d cycles",
                     level ? "high" : "low", limit);
            abort_run();
        end
    endtask

    initial begin
        entry_t e;
        word_t  rdata;
        logic   err;
        int     wr_before;
        word_t  t1;
        word_t  t2;
        i_rst_n     = 1'b0;
        i_req_valid = 1'b0;
        i_req_we    = 1'b0;
        i_req_addr  = '0;
        i_req_wdata = '0;
        i_req_wmask = '0;
        preload_ram();
        build_table();
        repeat (16) @(posedge clk);
        i_rst_n <= 1'b1;
        @(posedge clk);
        check_irq("o_timer_irq", o_timer_irq, 1'b0);

        for (int i = 0; i < tbl.size(); i++) begin
            e = tbl[i];
            wr_before = ram_wr_count;
            do_access(e.we, e.addr, e.wdata, e.mask, rdata, err);
            check_err("o_resp_err", err, e.exp_err);
            if (e.chk_rdata) begin
                check_word("o_resp_rdata", rdata, e.exp_word);
            end
            // model write port settles by the falling edge
            @(negedge clk);
            if (ram_wr_count != wr_before + (e.exp_wr ? 1 : 0)) begin
                $display("[ERROR] %0t ram write count got %0d expected %0d", $time,
                         ram_wr_count, wr_before + (e.exp_wr ? 1 : 0));
                abort_run();
            end
            if (e.exp_wr) begin
                check_addr("o_ram_wr_addr", last_wr_addr, e.addr);
                check_word("o_ram_wr_data", last_wr_data, e.exp_word);
            end
        end

        // mtime restarts from zero and keeps counting
        do_access(1'b1, MTIME_ADDR, '0, 8'hFF, rdata, err);
        check_err("o_resp_err", err, 1'b0);
        do_access(1'b0, MTIME_ADDR, '0, '0, t1, err);
        check_err("o_resp_err", err, 1'b0);
        repeat (5 * TICK_DIV) @(posedge clk);
        do_access(1'b0, MTIME_ADDR, '0, '0, t2, err);
        check_err("o_resp_err", err, 1'b0);
        if (t2 < t1) begin
            $display("[ERROR] %0t mtime second read %h below first read %h", $time, t2, t1);
            abort_run();
        end
        check_irq("o_timer_irq", o_timer_irq, 1'b0);

        // small compare value raises the interrupt, which then stays high
        do_access(1'b1, MTIMECMP_ADDR, 64'h20, 8'hFF, rdata, err);
        check_err("o_resp_err", err, 1'b0);
        wait_irq(1'b1, 64 * TICK_DIV);
        do_access(1'b0, MTIMECMP_ADDR, '0, '0, rdata, err);
        check_err("o_resp_err", err, 1'b0);
        check_word("o_resp_rdata", rdata, 64'h20);
        check_irq("o_timer_irq", o_timer_irq, 1'b1);

        do_access(1'b1, MTIMECMP_ADDR, '1, 8'hFF, rdata, err);
        check_err("o_resp_err", err, 1'b0);
        wait_irq(1'b0, 8);
        do_access(1'b0, MTIMECMP_ADDR, '0, '0, rdata, err);
        check_err("o_resp_err", err, 1'b0);
        check_word("o_resp_rdata", rdata, '1);
        check_irq("o_timer_irq", o_timer_irq, 1'b0);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
